/* sources.f */
+incdir+dv
design/mips_pkg.sv
design/fetch_stage.sv
design/decode_stage.sv
design/execute_stage.sv
design/reg_file.sv
design/mips_core.sv
dv/tb_mips_core.sv

/* dv/isa_model.svh */
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

//////////////////////////////////////////////////
// Instruction encoders
//////////////////////////////////////////////////

function automatic word_t encode_rtype(input funct_e fn, input reg_idx_t rd,
		input reg_idx_t rs, input reg_idx_t rt);
	return {OP_SPECIAL, rs, rt, rd, 5'd0, fn};
endfunction

function automatic word_t encode_itype(input opcode_e op, input reg_idx_t rt,
		input reg_idx_t rs, input logic [15:0] imm);
	return {op, rs, rt, imm};
endfunction

//////////////////////////////////////////////////
// Reference model
//////////////////////////////////////////////////

// Architectural execution, one delay slot after each branch
task automatic run_model(input addr_t end_addr);
	addr_t    pc;
	addr_t    npc;
	addr_t    nnpc;
	word_t    ins;
	word_t    a;
	word_t    b;
	word_t    simm;
	word_t    res;
	reg_idx_t dst;
	logic     wr;
	int       steps;
	pc    = RESET_PC;
	npc   = RESET_PC + 32'd4;
	steps = 0;
	exp_trace.delete();
	for (int r = 0; r < NUM_REGS; r++) begin
		model_regs[r] = '0;
	end
	while (steps < 1000) begin
		exp_trace.push_back(pc);
		if (pc == end_addr) begin
			break;
		end
		ins  = rom[pc[9:2]];
		a    = model_regs[ins[25:21]];
		b    = model_regs[ins[20:16]];
		simm = {{16{ins[15]}}, ins[15:0]};
		dst  = ins[20:16];
		wr   = 1'b1;
		res  = '0;
		nnpc = npc + 32'd4;
		case (opcode_e'(ins[31:26]))
			OP_SPECIAL: begin
				dst = ins[15:11];
				case (funct_e'(ins[5:0]))
					F_ADDU:  res = a + b;
					F_SUBU:  res = a - b;
					F_AND:   res = a & b;
					F_OR:    res = a | b;
					F_XOR:   res = a ^ b;
					F_SLT:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					default: wr = 1'b0;
				endcase
			end
			OP_ADDIU: res = a + simm;
			OP_ORI:   res = a | {16'h0000, ins[15:0]};
			OP_LUI:   res = {ins[15:0], 16'h0000};
			OP_BEQ: begin
				wr = 1'b0;
				if (a == b) begin
					nnpc = pc + 32'd4 + (simm << 2);
				end
			end
			OP_BNE: begin
				wr = 1'b0;
				if (a != b) begin
					nnpc = pc + 32'd4 + (simm << 2);
				end
			end
			default: wr = 1'b0;
		endcase
		if (wr && dst != 5'd0) begin
			model_regs[dst] = res;
		end
		pc  = npc;
		npc = nnpc;
		steps++;
	end
endtask

// 150 instructions on r0..r7, forward branches only
task automatic gen_random_program();
	word_t    r;
	int       kind;
	int       off;
	logic     prev_branch;
	opcode_e  bop;
	reg_idx_t rd;
	reg_idx_t rs;
	reg_idx_t rt;
	prev_branch = 1'b0;
	for (int i = 0; i < 150; i++) begin
		r    = next_rand();
		rd   = {2'b00, r[18:16]};
		rs   = {2'b00, r[21:19]};
		rt   = {2'b00, r[24:22]};
		kind = r[15:8] % 8'd11;
		// No branch in a delay slot or ahead of the end loop
		if (kind >= 9 && (prev_branch || i == 149)) begin
			kind = kind - 9;
		end
		prev_branch = (kind >= 9);
		case (kind)
			0: emit(encode_rtype(F_ADDU, rd, rs, rt));
			1: emit(encode_rtype(F_SUBU, rd, rs, rt));
			2: emit(encode_rtype(F_AND, rd, rs, rt));
			3: emit(encode_rtype(F_OR, rd, rs, rt));
			4: emit(encode_rtype(F_XOR, rd, rs, rt));
			5: emit(encode_rtype(F_SLT, rd, rs, rt));
			6: emit(encode_itype(OP_ADDIU, rt, rs, {{11{r[29]}}, r[29:25]}));
			7: emit(encode_itype(OP_ORI, rt, rs, {8'h00, r[31:24]}));
			8: emit(encode_itype(OP_LUI, rt, 5'd0, {8'h00, r[31:24]}));
			default: begin
				off = 1 + int'(r[27:25]);
				if (i + 1 + off > 150) begin
					off = 149 - i;
				end
				if (kind == 9) begin
					bop = OP_BEQ;
				end else begin
					bop = OP_BNE;
				end
				emit(encode_itype(bop, rt, rs, off[15:0]));
			end
		endcase
	end
endtask

`endif

/* dv/tb_mips_core.sv */
`default_nettype none

module tb_mips_core;
	import mips_pkg::*;

	logic     clk;
	logic     rst_i;
	word_t    inst_i;
	addr_t    inst_addr_o;
	addr_t    pc_o;
	reg_idx_t dbg_addr_i;
	word_t    dbg_data_o;

	word_t rom [256];
	word_t model_regs [NUM_REGS];
	addr_t exp_trace [$];
	word_t lcg_state;
	int    prog_len;

	mips_core UUT (
		.clk(clk),
		.rst_i(rst_i),
		.inst_i(inst_i),
		.inst_addr_o(inst_addr_o),
		.pc_o(pc_o),
		.dbg_addr_i(dbg_addr_i),
		.dbg_data_o(dbg_data_o)
	);

	// Combinational instruction ROM
	assign inst_i = rom[inst_addr_o[9:2]];

	always #4 clk = ~clk;

	function automatic word_t next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic emit(input word_t instr);
		rom[prog_len] = instr;
		prog_len++;
	endtask

	`include "isa_model.svh"

	//////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input word_t exp, input word_t act);
		if (act !== exp) begin
			stop_on_error($sformatf("[ERROR] %s: expected %08h, actual %08h", name, exp, act));
		end
	endtask

	task automatic check_pc(input string name, input addr_t exp, input addr_t act);
		if (act !== exp) begin
			stop_on_error($sformatf("[ERROR] %s: expected %08h, actual %08h", name, exp, act));
		end
	endtask

	//////////////////////////////////////////////////
	// Program and run control
	//////////////////////////////////////////////////

	task automatic clear_rom();
		for (int i = 0; i < 256; i++) begin
			// Filler only targets r0
			rom[i] = encode_itype(OP_ORI, 5'd0, 5'd0, i[15:0]);
		end
		prog_len = 0;
	endtask

	// Self-loop plus a NOP in its delay slot
	task automatic close_program(output addr_t end_addr);
		end_addr = prog_len * 4;
		emit(encode_itype(OP_BEQ, 5'd0, 5'd0, 16'hffff));
		emit(NOP_INSTR);
	endtask

	task automatic assert_reset();
		@(posedge clk);
		rst_i <= 1'b1;
		@(negedge clk);
	endtask

	task automatic read_dbg(input reg_idx_t idx, output word_t val);
		@(posedge clk);
		dbg_addr_i <= idx;
		@(negedge clk);
		val = dbg_data_o;
	endtask

	task automatic run_program(input string name, input addr_t end_addr);
		int    cycle;
		word_t val;
		run_model(end_addr);
		repeat (5) @(posedge clk);
		rst_i <= 1'b0;
		cycle = 0;
		// PC trace until the end loop is fetched
		forever begin
			@(negedge clk);
			check_pc($sformatf("%s pc[%0d]", name, cycle), exp_trace[cycle], pc_o);
			check_pc($sformatf("%s inst_addr[%0d]", name, cycle), exp_trace[cycle],
				inst_addr_o);
			if (pc_o == end_addr) begin
				break;
			end
			cycle++;
			if (cycle >= 1000) begin
				stop_on_error($sformatf("%s: PC never reached the end loop in 1000 cycles", name));
			end
		end
		// Drain the pipeline
		repeat (8) @(posedge clk);
		for (int r = 0; r < NUM_REGS; r++) begin
			read_dbg(r[4:0], val);
			check_word($sformatf("%s r%0d", name, r), model_regs[r], val);
		end
	endtask

	initial begin
		addr_t end_addr;
		word_t val;
		clk        = 1'b0;
		rst_i      = 1'b1;
		dbg_addr_i = '0;
		lcg_state  = 32'h5cb464f7;
		clear_rom();

		// Back-to-back dependencies at distances 1, 2 and 3
		assert_reset();
		clear_rom();
		emit(encode_itype(OP_ADDIU, 5'd1, 5'd0, 16'd5));
		emit(encode_itype(OP_ADDIU, 5'd2, 5'd1, 16'd3));
		emit(encode_rtype(F_ADDU, 5'd3, 5'd1, 5'd2));
		emit(encode_rtype(F_SUBU, 5'd4, 5'd3, 5'd1));
		emit(encode_rtype(F_XOR, 5'd5, 5'd4, 5'd2));
		emit(encode_rtype(F_OR, 5'd6, 5'd5, 5'd3));
		emit(encode_itype(OP_ADDIU, 5'd0, 5'd1, 16'd7));
		emit(encode_rtype(F_ADDU, 5'd7, 5'd0, 5'd6));
		emit(encode_rtype(F_ADDU, 5'd0, 5'd7, 5'd7));
		emit(encode_itype(OP_BNE, 5'd7, 5'd6, 16'd1));
		emit(encode_rtype(F_AND, 5'd1, 5'd7, 5'd2));
		close_program(end_addr);
		run_program("forwarding", end_addr);
		read_dbg(5'd0, val);
		check_word("r0 after writes", 32'd0, val);
		read_dbg(5'd4, val);
		check_word("distance 3 bypass", 32'd8, val);
		read_dbg(5'd7, val);
		check_word("distance 1 forward", 32'd13, val);

		// Full constant, signed compares, taken branch
		assert_reset();
		clear_rom();
		emit(encode_itype(OP_LUI, 5'd1, 5'd0, 16'h89ab));
		emit(encode_itype(OP_ORI, 5'd1, 5'd1, 16'hcdef));
		emit(encode_itype(OP_ADDIU, 5'd2, 5'd0, 16'hfffd));
		emit(encode_itype(OP_ADDIU, 5'd3, 5'd0, 16'hffff));
		emit(encode_rtype(F_SLT, 5'd4, 5'd2, 5'd3));
		emit(encode_rtype(F_SLT, 5'd5, 5'd3, 5'd2));
		emit(encode_rtype(F_SLT, 5'd6, 5'd1, 5'd0));
		emit(encode_itype(OP_BEQ, 5'd4, 5'd6, 16'd2));
		emit(encode_itype(OP_ADDIU, 5'd7, 5'd0, 16'd1));
		emit(encode_itype(OP_ADDIU, 5'd7, 5'd7, 16'd1));
		emit(encode_rtype(F_XOR, 5'd5, 5'd7, 5'd1));
		close_program(end_addr);
		run_program("lui_ori_slt", end_addr);
		read_dbg(5'd1, val);
		check_word("lui ori constant", 32'h89ab_cdef, val);
		read_dbg(5'd4, val);
		check_word("slt negative", 32'd1, val);
		read_dbg(5'd7, val);
		check_word("delay slot only", 32'd1, val);

		for (int p = 0; p < 3; p++) begin
			assert_reset();
			clear_rom();
			gen_random_program();
			close_program(end_addr);
			run_program($sformatf("random%0d", p), end_addr);
		end

		$display("Simulation passed");
		$finish;
	end

endmodule

`default_nettype wire

/* design/mips_core.sv */
`default_nettype none

module mips_core (
	input  logic               clk,
	input  logic               rst_i,
	input  mips_pkg::word_t    inst_i,
	output mips_pkg::addr_t    inst_addr_o,
	output mips_pkg::addr_t    pc_o,
	input  mips_pkg::reg_idx_t dbg_addr_i,
	output mips_pkg::word_t    dbg_data_o
);
	import mips_pkg::*;

	addr_t    if_pc;
	word_t    if_instr;
	logic     branch_taken;
	addr_t    branch_target;
	reg_idx_t rs_addr;
	reg_idx_t rt_addr;
	word_t    rs_data;
	word_t    rt_data;
	alu_op_e  alu_op;
	word_t    op_a;
	word_t    op_b;
	reg_idx_t dest;
	logic     dest_we;
	reg_idx_t ex_dest;
	logic     ex_we;
	word_t    ex_result;
	reg_idx_t wb_dest;
	logic     wb_we;
	word_t    wb_data;

	// PC is also the visible status output
	assign pc_o = inst_addr_o;

	fetch_stage fetch0 (.clk(clk), .rst_i(rst_i),
		.branch_taken_i(branch_taken), .branch_target_i(branch_target),
		.inst_i(inst_i), .pc_o(inst_addr_o),
		.if_pc_o(if_pc), .if_instr_o(if_instr));

	decode_stage decode0 (.clk(clk), .rst_i(rst_i),
		.if_pc_i(if_pc), .if_instr_i(if_instr),
		.rs_addr_o(rs_addr), .rt_addr_o(rt_addr),
		.rs_data_i(rs_data), .rt_data_i(rt_data),
		.ex_dest_i(ex_dest), .ex_we_i(ex_we), .ex_result_i(ex_result),
		.wb_dest_i(wb_dest), .wb_we_i(wb_we), .wb_data_i(wb_data),
		.branch_taken_o(branch_taken), .branch_target_o(branch_target),
		.alu_op_o(alu_op), .op_a_o(op_a), .op_b_o(op_b),
		.dest_o(dest), .dest_we_o(dest_we));

	execute_stage execute0 (.clk(clk), .rst_i(rst_i),
		.alu_op_i(alu_op), .op_a_i(op_a), .op_b_i(op_b),
		.dest_i(dest), .dest_we_i(dest_we),
		.ex_dest_o(ex_dest), .ex_we_o(ex_we), .ex_result_o(ex_result),
		.wb_dest_o(wb_dest), .wb_we_o(wb_we), .wb_data_o(wb_data));

	reg_file reg_file0 (.clk(clk), .rst_i(rst_i),
		.we_i(wb_we), .waddr_i(wb_dest), .wdata_i(wb_data),
		.raddr1_i(rs_addr), .rdata1_o(rs_data),
		.raddr2_i(rt_addr), .rdata2_o(rt_data),
		.dbg_addr_i(dbg_addr_i), .dbg_data_o(dbg_data_o));

endmodule

`default_nettype wire

/* design/reg_file.sv */
`default_nettype none

module reg_file (
	input  logic               clk,
	input  logic               rst_i,
	input  logic               we_i,
	input  mips_pkg::reg_idx_t waddr_i,
	input  mips_pkg::word_t    wdata_i,
	input  mips_pkg::reg_idx_t raddr1_i,
	output mips_pkg::word_t    rdata1_o,
	input  mips_pkg::reg_idx_t raddr2_i,
	output mips_pkg::word_t    rdata2_o,
	input  mips_pkg::reg_idx_t dbg_addr_i,
	output mips_pkg::word_t    dbg_data_o
);
	import mips_pkg::*;

	word_t regs [NUM_REGS];

	always_ff @(posedge clk) begin
		if (rst_i) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we_i && waddr_i != 5'd0) begin
			regs[waddr_i] <= wdata_i;
		end
	end

	// r0 reads zero, same-cycle write bypasses the array
	function automatic word_t read_port(input reg_idx_t addr);
		if (addr == 5'd0) begin
			return '0;
		end else if (we_i && waddr_i == addr) begin
			return wdata_i;
		end
		return regs[addr];
	endfunction

	always_comb begin
		rdata1_o   = read_port(raddr1_i);
		rdata2_o   = read_port(raddr2_i);
		dbg_data_o = read_port(dbg_addr_i);
	end

endmodule

`default_nettype wire

/* design/execute_stage.sv */
`default_nettype none

module execute_stage (
	input  logic               clk,
	input  logic               rst_i,
	input  mips_pkg::alu_op_e  alu_op_i,
	input  mips_pkg::word_t    op_a_i,
	input  mips_pkg::word_t    op_b_i,
	input  mips_pkg::reg_idx_t dest_i,
	input  logic               dest_we_i,
	output mips_pkg::reg_idx_t ex_dest_o,
	output logic               ex_we_o,
	output mips_pkg::word_t    ex_result_o,
	output mips_pkg::reg_idx_t wb_dest_o,
	output logic               wb_we_o,
	output mips_pkg::word_t    wb_data_o
);
	import mips_pkg::*;

	word_t alu_result;

	//////////////////////////////////////////////////
	// ALU
	//////////////////////////////////////////////////

	always_comb begin
		case (alu_op_i)
			ALU_ADD: alu_result = op_a_i + op_b_i;
			ALU_SUB: alu_result = op_a_i - op_b_i;
			ALU_AND: alu_result = op_a_i & op_b_i;
			ALU_OR:  alu_result = op_a_i | op_b_i;
			ALU_XOR: alu_result = op_a_i ^ op_b_i;
			// Signed compare
			ALU_SLT: alu_result = {31'b0, ($signed(op_a_i) < $signed(op_b_i))};
			// Immediate arrives already shifted
			ALU_LUI: alu_result = op_b_i;
			default: alu_result = '0;
		endcase
	end

	// Result seen by decode in the same cycle
	assign ex_dest_o   = dest_i;
	assign ex_we_o     = dest_we_i;
	assign ex_result_o = alu_result;

	// EX/WB register
	always_ff @(posedge clk) begin
		if (rst_i) begin
			wb_we_o <= 1'b0;
		end else begin
			wb_we_o <= dest_we_i;
		end
	end

	always_ff @(posedge clk) begin
		wb_dest_o <= dest_i;
		wb_data_o <= alu_result;
	end

endmodule

`default_nettype wire

/* design/decode_stage.sv */
`default_nettype none

module decode_stage (
	input  logic               clk,
	input  logic               rst_i,
	input  mips_pkg::addr_t    if_pc_i,
	input  mips_pkg::word_t    if_instr_i,
	output mips_pkg::reg_idx_t rs_addr_o,
	output mips_pkg::reg_idx_t rt_addr_o,
	input  mips_pkg::word_t    rs_data_i,
	input  mips_pkg::word_t    rt_data_i,
	input  mips_pkg::reg_idx_t ex_dest_i,
	input  logic               ex_we_i,
	input  mips_pkg::word_t    ex_result_i,
	input  mips_pkg::reg_idx_t wb_dest_i,
	input  logic               wb_we_i,
	input  mips_pkg::word_t    wb_data_i,
	output logic               branch_taken_o,
	output mips_pkg::addr_t    branch_target_o,
	output mips_pkg::alu_op_e  alu_op_o,
	output mips_pkg::word_t    op_a_o,
	output mips_pkg::word_t    op_b_o,
	output mips_pkg::reg_idx_t dest_o,
	output logic               dest_we_o
);
	import mips_pkg::*;

	opcode_e     opcode;
	funct_e      funct;
	reg_idx_t    rs;
	reg_idx_t    rt;
	reg_idx_t    rd;
	logic [15:0] imm;

	alu_op_e  alu_op;
	reg_idx_t dest;
	logic     dest_we;
	logic     use_imm;
	word_t    imm_ext;
	logic     is_beq;
	logic     is_bne;
	word_t    rs_val;
	word_t    rt_val;

	assign opcode = opcode_e'(if_instr_i[31:26]);
	assign funct  = funct_e'(if_instr_i[5:0]);
	assign rs     = if_instr_i[25:21];
	assign rt     = if_instr_i[20:16];
	assign rd     = if_instr_i[15:11];
	assign imm    = if_instr_i[15:0];

	//////////////////////////////////////////////////
	// Instruction decode
	//////////////////////////////////////////////////

	always_comb begin
		alu_op  = ALU_NOP;
		dest    = rt;
		dest_we = 1'b0;
		use_imm = 1'b0;
		imm_ext = {{16{imm[15]}}, imm};
		is_beq  = 1'b0;
		is_bne  = 1'b0;
		case (opcode)
			OP_SPECIAL: begin
				dest    = rd;
				dest_we = 1'b1;
				case (funct)
					F_ADDU:  alu_op = ALU_ADD;
					F_SUBU:  alu_op = ALU_SUB;
					F_AND:   alu_op = ALU_AND;
					F_OR:    alu_op = ALU_OR;
					F_XOR:   alu_op = ALU_XOR;
					F_SLT:   alu_op = ALU_SLT;
					default: dest_we = 1'b0;
				endcase
			end
			OP_ADDIU: begin
				alu_op  = ALU_ADD;
				dest_we = 1'b1;
				use_imm = 1'b1;
			end
			OP_ORI: begin
				alu_op  = ALU_OR;
				dest_we = 1'b1;
				use_imm = 1'b1;
				imm_ext = {16'h0000, imm};
			end
			OP_LUI: begin
				alu_op  = ALU_LUI;
				dest_we = 1'b1;
				use_imm = 1'b1;
				imm_ext = {imm, 16'h0000};
			end
			OP_BEQ:  is_beq = 1'b1;
			OP_BNE:  is_bne = 1'b1;
			default: alu_op = ALU_NOP;
		endcase
		// r0 is never written
		if (dest == 5'd0) begin
			dest_we = 1'b0;
		end
	end

	//////////////////////////////////////////////////
	// Operand forwarding and branches
	//////////////////////////////////////////////////

	assign rs_addr_o = rs;
	assign rt_addr_o = rt;

	// Youngest producer first
	assign rs_val = (ex_we_i && ex_dest_i == rs) ? ex_result_i :
	                (wb_we_i && wb_dest_i == rs) ? wb_data_i : rs_data_i;
	assign rt_val = (ex_we_i && ex_dest_i == rt) ? ex_result_i :
	                (wb_we_i && wb_dest_i == rt) ? wb_data_i : rt_data_i;

	assign branch_taken_o  = (is_beq && rs_val == rt_val) || (is_bne && rs_val != rt_val);
	assign branch_target_o = if_pc_i + 32'd4 + {{14{imm[15]}}, imm, 2'b00};

	// ID/EX register
	always_ff @(posedge clk) begin
		if (rst_i) begin
			alu_op_o  <= ALU_NOP;
			dest_we_o <= 1'b0;
		end else begin
			alu_op_o  <= alu_op;
			dest_we_o <= dest_we;
		end
	end

	always_ff @(posedge clk) begin
		op_a_o <= rs_val;
		op_b_o <= use_imm ? imm_ext : rt_val;
		dest_o <= dest;
	end

endmodule

`default_nettype wire

/* design/fetch_stage.sv */
`default_nettype none

module fetch_stage (
	input  logic            clk,
	input  logic            rst_i,
	input  logic            branch_taken_i,
	input  mips_pkg::addr_t branch_target_i,
	input  mips_pkg::word_t inst_i,
	output mips_pkg::addr_t pc_o,
	output mips_pkg::addr_t if_pc_o,
	output mips_pkg::word_t if_instr_o
);
	import mips_pkg::*;

	addr_t pc;
	addr_t next_pc;

	// Branch redirect from decode, else sequential
	assign next_pc = branch_taken_i ? branch_target_i : pc + 32'd4;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			pc <= RESET_PC;
		end else begin
			pc <= next_pc;
		end
	end

	assign pc_o = pc;

	// IF/ID register
	always_ff @(posedge clk) begin
		if (rst_i) begin
			if_pc_o    <= RESET_PC;
			if_instr_o <= NOP_INSTR;
		end else begin
			if_pc_o    <= pc;
			if_instr_o <= inst_i;
		end
	end

endmodule

`default_nettype wire

/* design/mips_pkg.sv */
`default_nettype none

package mips_pkg;

	typedef logic [31:0] word_t;
	typedef logic [31:0] addr_t;
	typedef logic [4:0]  reg_idx_t;

	localparam addr_t RESET_PC  = 32'h0000_0000;
	localparam int    NUM_REGS  = 32;
	localparam word_t NOP_INSTR = 32'h0000_0000;

	//////////////////////////////////////////////////
	// Instruction encodings
	//////////////////////////////////////////////////

	// Primary opcode, bits 31:26
	typedef enum logic [5:0] {
		OP_SPECIAL = 6'h00,
		OP_BEQ     = 6'h04,
		OP_BNE     = 6'h05,
		OP_ADDIU   = 6'h09,
		OP_ORI     = 6'h0d,
		OP_LUI     = 6'h0f
	} opcode_e;

	// SPECIAL function field, bits 5:0
	typedef enum logic [5:0] {
		F_ADDU = 6'h21,
		F_SUBU = 6'h23,
		F_AND  = 6'h24,
		F_OR   = 6'h25,
		F_XOR  = 6'h26,
		F_SLT  = 6'h2a
	} funct_e;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_LUI,
		ALU_NOP
	} alu_op_e;

endpackage

`default_nettype wire
